/* csd_fir_config.svh */
// Fixed 16-bit sample and 32-bit result; the digit masks must keep each product inside 32 bits.
`ifndef CSD_FIR_CONFIG_SVH
`define CSD_FIR_CONFIG_SVH

`define CSD_FIR_DATA_W 16
`define CSD_FIR_ACC_W 32
`define CSD_FIR_TAPS 4
`define CSD_FIR_ADDR_W 8

// APB register offsets.
`define CSD_FIR_REG_SAMPLE 8'h00
`define CSD_FIR_REG_RESULT 8'h04
`define CSD_FIR_REG_STATUS 8'h08
`define CSD_FIR_REG_CTRL 8'h0C

// Signed-digit masks, bit k adds or subtracts x shifted by k.
`define CSD_FIR_COEF0_POS 16'h0000
`define CSD_FIR_COEF0_NEG 16'h0092
`define CSD_FIR_COEF1_POS 16'h0080
`define CSD_FIR_COEF1_NEG 16'h0829
`define CSD_FIR_COEF2_POS 16'h0902
`define CSD_FIR_COEF2_NEG 16'h0040
`define CSD_FIR_COEF3_POS 16'h4110
`define CSD_FIR_COEF3_NEG 16'h1045

`endif

/* logic/csd_fir_pkg.sv */
// APB data bus is fixed at 32 bits; address width follows the config header.
`include "csd_fir_config.svh"

package csd_fir_pkg;

    // Master to slave, one APB transfer.
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`CSD_FIR_ADDR_W-1:0] paddr;
        logic [31:0]                pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // One sample pulse into the filter.
    typedef struct packed {
        logic                              valid;
        logic signed [`CSD_FIR_DATA_W-1:0] data;
    } fir_sample_t;

    // Index t holds the product for tap t.
    typedef logic signed [`CSD_FIR_TAPS-1:0][`CSD_FIR_ACC_W-1:0] fir_products_t;

endpackage

/* logic/csd_multiplier.sv */
// Purely combinational; the product is exact only while x times the coefficient fits the result.
`timescale 1ns/1ps
`include "csd_fir_config.svh"

module csd_multiplier #(
    parameter logic [`CSD_FIR_DATA_W-1:0] POS_DIGITS = '0,
    parameter logic [`CSD_FIR_DATA_W-1:0] NEG_DIGITS = '0
) (
    input  logic signed [`CSD_FIR_DATA_W-1:0] x,
    output logic signed [`CSD_FIR_ACC_W-1:0]  product
);

    localparam int DW = `CSD_FIR_DATA_W;
    localparam int AW = `CSD_FIR_ACC_W;

    function automatic int ones_below(input logic [DW-1:0] mask, input int pos);
        int n;
        n = 0;
        for (int i = 0; i < pos; i++) begin
            n += int'(mask[i]);
        end
        return n;
    endfunction

    // Rows left after a number of 3:2 layers.
    function automatic int rows_after(input int n_in, input int layers);
        int n;
        n = n_in;
        for (int l = 0; l < layers; l++) begin
            n = (n / 3) * 2 + (n % 3);
        end
        return n;
    endfunction

    function automatic int layer_total(input int n_in);
        int n;
        int l;
        n = n_in;
        l = 0;
        while (n > 2) begin
            n = (n / 3) * 2 + (n % 3);
            l++;
        end
        return l;
    endfunction

    localparam int N_POS   = ones_below(POS_DIGITS, DW);
    localparam int N_TERMS = N_POS + ones_below(NEG_DIGITS, DW);
    localparam int LAYERS  = layer_total(N_TERMS);
    localparam int ROW_W   = (N_TERMS < 2) ? 2 : N_TERMS;

    logic signed [AW-1:0] x_ext;
    logic signed [AW-1:0] row [LAYERS+1][ROW_W];

    assign x_ext = {{(AW - DW){x[DW-1]}}, x};

    for (genvar k = 0; k < DW; k++) begin : g_digit
        if (POS_DIGITS[k]) begin : g_pos
            assign row[0][ones_below(POS_DIGITS, k)] = x_ext << k;
        end
        if (NEG_DIGITS[k]) begin : g_neg
            assign row[0][N_POS + ones_below(NEG_DIGITS, k)] = -(x_ext << k);
        end
    end
    for (genvar i = N_TERMS; i < ROW_W; i++) begin : g_fill0
        assign row[0][i] = '0;
    end

    for (genvar l = 0; l < LAYERS; l++) begin : g_layer
        localparam int N_IN  = rows_after(N_TERMS, l);
        localparam int N_GRP = N_IN / 3;
        localparam int N_OUT = rows_after(N_TERMS, l + 1);

        for (genvar g = 0; g < N_GRP; g++) begin : g_csa
            logic [AW-1:0] a;
            logic [AW-1:0] b;
            logic [AW-1:0] c;
            logic [AW-1:0] maj;
            assign a   = row[l][3*g];
            assign b   = row[l][3*g+1];
            assign c   = row[l][3*g+2];
            assign maj = (a & b) | (b & c) | (a & c);
            assign row[l+1][2*g]   = a ^ b ^ c;
            assign row[l+1][2*g+1] = {maj[AW-2:0], 1'b0}; // Carry weighs one bit up.
        end
        for (genvar r = 0; r < N_IN - 3 * N_GRP; r++) begin : g_pass
            assign row[l+1][2*N_GRP+r] = row[l][3*N_GRP+r];
        end
        for (genvar i = N_OUT; i < ROW_W; i++) begin : g_fill
            assign row[l+1][i] = '0;
        end
    end

    assign product = row[LAYERS][0] + row[LAYERS][1]; // Single carry-propagate add.

endmodule

/* logic/fir_datapath.sv */
// Advances only on a valid sample; clear and a valid sample are expected never to coincide.
`timescale 1ns/1ps
`include "csd_fir_config.svh"

module fir_datapath (
    input  logic                             pclk,
    input  logic                             rst_n,
    input  csd_fir_pkg::fir_sample_t         sample,
    input  logic                             clear,
    output logic signed [`CSD_FIR_ACC_W-1:0] result
);

    localparam int TAPS = `CSD_FIR_TAPS;
    localparam int DW   = `CSD_FIR_DATA_W;
    localparam int AW   = `CSD_FIR_ACC_W;

    localparam logic [TAPS-1:0][DW-1:0] POS_MASKS = {
        `CSD_FIR_COEF3_POS,
        `CSD_FIR_COEF2_POS,
        `CSD_FIR_COEF1_POS,
        `CSD_FIR_COEF0_POS
    };
    localparam logic [TAPS-1:0][DW-1:0] NEG_MASKS = {
        `CSD_FIR_COEF3_NEG,
        `CSD_FIR_COEF2_NEG,
        `CSD_FIR_COEF1_NEG,
        `CSD_FIR_COEF0_NEG
    };

    csd_fir_pkg::fir_products_t products;

    // Partial sums of the transposed form, z[1] is nearest the output.
    logic signed [AW-1:0] z [1:TAPS-1];

    for (genvar t = 0; t < TAPS; t++) begin : g_tap
        csd_multiplier #(
            .POS_DIGITS(POS_MASKS[t]),
            .NEG_DIGITS(NEG_MASKS[t])
        ) u_mul (
            .x      (sample.data),
            .product(products[t])
        );
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            for (int t = 1; t < TAPS; t++) begin
                z[t] <= '0;
            end
        end else if (clear) begin
            result <= '0;
            for (int t = 1; t < TAPS; t++) begin
                z[t] <= '0;
            end
        end else if (sample.valid) begin
            result <= products[0] + z[1];
            for (int t = 1; t < TAPS - 1; t++) begin
                z[t] <= products[t] + z[t+1];
            end
            z[TAPS-1] <= products[TAPS-1]; // Oldest tap starts the chain.
        end
    end

endmodule

/* logic/fir_apb_regs.sv */
// Zero-wait-state APB slave; read data and pslverr are captured in the setup phase.
`timescale 1ns/1ps
`include "csd_fir_config.svh"

module fir_apb_regs (
    input  logic                             pclk,
    input  logic                             rst_n,
    input  csd_fir_pkg::apb_req_t            apb_req,
    output csd_fir_pkg::apb_rsp_t            apb_rsp,
    input  logic signed [`CSD_FIR_ACC_W-1:0] result,
    output csd_fir_pkg::fir_sample_t         sample,
    output logic                             clear
);

    logic        setup;
    logic        access;
    logic        hit_sample;
    logic        hit_result;
    logic        hit_status;
    logic        hit_ctrl;
    logic        bad_access;
    logic        rd_result;
    logic [31:0] rdata;
    logic [31:0] prdata_q;
    logic        pslverr_q;
    logic        result_valid;
    logic        overrun;

    assign setup  = apb_req.psel & ~apb_req.penable;
    assign access = apb_req.psel & apb_req.penable;

    assign hit_sample = (apb_req.paddr == `CSD_FIR_REG_SAMPLE);
    assign hit_result = (apb_req.paddr == `CSD_FIR_REG_RESULT);
    assign hit_status = (apb_req.paddr == `CSD_FIR_REG_STATUS);
    assign hit_ctrl   = (apb_req.paddr == `CSD_FIR_REG_CTRL);

    // SAMPLE and CTRL are write only, RESULT and STATUS read only.
    always_comb begin
        if (hit_sample || hit_ctrl) begin
            bad_access = ~apb_req.pwrite;
        end else if (hit_result || hit_status) begin
            bad_access = apb_req.pwrite;
        end else begin
            bad_access = 1'b1;
        end
    end

    always_comb begin
        rdata = '0;
        if (hit_result) begin
            rdata = result;
        end else if (hit_status) begin
            rdata = {30'd0, overrun, result_valid};
        end
    end

    assign sample.valid = access & apb_req.pwrite & hit_sample;
    assign sample.data  = apb_req.pwdata[`CSD_FIR_DATA_W-1:0];
    assign clear        = access & apb_req.pwrite & hit_ctrl & apb_req.pwdata[0];
    assign rd_result    = access & ~apb_req.pwrite & hit_result;

    // Captured on the edge ending setup, so valid through the access cycle.
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else begin
            prdata_q  <= (setup && !apb_req.pwrite && !bad_access) ? rdata : '0;
            pslverr_q <= setup & bad_access;
        end
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            overrun      <= 1'b0;
        end else if (clear) begin
            result_valid <= 1'b0;
            overrun      <= 1'b0;
        end else if (sample.valid) begin
            result_valid <= 1'b1;
            if (result_valid) begin
                overrun <= 1'b1; // Previous result never read.
            end
        end else if (rd_result) begin
            result_valid <= 1'b0;
        end
    end

    always_comb begin
        apb_rsp.prdata  = prdata_q;
        apb_rsp.pready  = 1'b1; // No wait states.
        apb_rsp.pslverr = pslverr_q;
    end

endmodule

/* logic/csd_fir_top.sv */
// Single APB slave with no back-pressure; a sample written before the result is read sets overrun.
`timescale 1ns/1ps
`include "csd_fir_config.svh"

module csd_fir_top (
    input  logic                  pclk,
    input  logic                  rst_n,
    input  csd_fir_pkg::apb_req_t apb_req,
    output csd_fir_pkg::apb_rsp_t apb_rsp
);

    csd_fir_pkg::fir_sample_t         sample;
    logic                             clear;
    logic signed [`CSD_FIR_ACC_W-1:0] result;

    fir_apb_regs u_regs (
        .pclk   (pclk),
        .rst_n  (rst_n),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .result (result),
        .sample (sample),
        .clear  (clear)
    );

    fir_datapath u_datapath (
        .pclk  (pclk),
        .rst_n (rst_n),
        .sample(sample),
        .clear (clear),
        .result(result)
    );

endmodule

/* bench/csd_fir_properties.sv */
// Assumes the zero-wait-state APB of csd_fir_top; the flag checks reach into the register block.
`timescale 1ns/1ps

module csd_fir_properties (
    input logic                     pclk,
    input logic                     rst_n,
    input csd_fir_pkg::apb_req_t    apb_req,
    input csd_fir_pkg::apb_rsp_t    apb_rsp,
    input csd_fir_pkg::fir_sample_t sample,
    input logic                     clear,
    input logic                     result_valid,
    input logic                     overrun
);

    logic access;

    assign access = apb_req.psel & apb_req.penable;

    a_pready: assert property (@(posedge pclk) disable iff (!rst_n)
        access |-> apb_rsp.pready)
        else $error("pready low during an APB access phase");

    a_pslverr: assert property (@(posedge pclk) disable iff (!rst_n)
        apb_rsp.pslverr |-> access)
        else $error("pslverr high outside an APB access phase");

    a_pulses: assert property (@(posedge pclk) disable iff (!rst_n)
        !(clear && sample.valid))
        else $error("clear and sample valid high in the same cycle");

    // Overrun may only rise one edge after a sample met an unread result.
    a_overrun: assert property (@(posedge pclk) disable iff (!rst_n)
        $rose(overrun) |-> $past(sample.valid && result_valid))
        else $error("overrun rose without a sample on an unread result");

endmodule

bind csd_fir_top csd_fir_properties u_props (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .sample      (sample),
    .clear       (clear),
    .result_valid(u_regs.result_valid),
    .overrun     (u_regs.overrun)
);

/* bench/csd_fir_tb.sv */
// Zero-wait-state APB only; expected results come from the integer coefficients, not the masks.
`timescale 1ns/1ps
`include "csd_fir_config.svh"

module csd_fir_tb;

    localparam int TIMEOUT = 20;
    localparam int C0 = -146;
    localparam int C1 = -1961;
    localparam int C2 = 2242;
    localparam int C3 = 12491;

    logic                  pclk;
    logic                  rst_n;
    csd_fir_pkg::apb_req_t apb_req;
    csd_fir_pkg::apb_rsp_t apb_rsp;

    int fails;
    int tests_run;
    int hist [3]; // Reference history, index 0 is newest.

    csd_fir_top dut (
        .pclk   (pclk),
        .rst_n  (rst_n),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    always #5 pclk = ~pclk;

    task automatic model_clear();
        for (int i = 0; i < 3; i++) begin
            hist[i] = 0;
        end
    endtask

    function automatic int model_step(input int x);
        int y;
        y = C0 * x + C1 * hist[0] + C2 * hist[1] + C3 * hist[2];
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = x;
        return y;
    endfunction

    task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %0d actual %0d", test, $signed(exp), $signed(act));
            fails++;
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int n;
        @(posedge pclk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge pclk);
        #1;
        apb_req.penable = 1'b1;
        n = 0;
        while (!apb_rsp.pready && n < TIMEOUT) begin
            @(posedge pclk);
            #1;
            n++;
        end
        if (!apb_rsp.pready) begin
            $display("APB access to offset 0x%02h timed out waiting for pready", addr);
            fails++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge pclk); // Access completes on this edge.
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic read_and_check(input string test, input logic [7:0] addr, input int exp);
        logic [31:0] d;
        logic        e;
        apb_read(addr, d, e);
        check_value(test, 32'd0, {31'd0, e});
        check_value(test, exp, d);
    endtask

    // One sample in, one RESULT read compared with the reference.
    task automatic feed_and_check(input string test, input int x);
        logic e;
        int   y;
        apb_write(`CSD_FIR_REG_SAMPLE, x, e);
        check_value(test, 32'd0, {31'd0, e});
        y = model_step(x);
        read_and_check(test, `CSD_FIR_REG_RESULT, y);
    endtask

    task automatic write_only(input string test, input int x);
        logic e;
        apb_write(`CSD_FIR_REG_SAMPLE, x, e);
        check_value(test, 32'd0, {31'd0, e});
        void'(model_step(x));
    endtask

    task automatic clear_filter(input string test);
        logic e;
        apb_write(`CSD_FIR_REG_CTRL, 32'd1, e);
        check_value(test, 32'd0, {31'd0, e});
        model_clear();
    endtask

    task automatic report_test(input string test, input int fails_before);
        tests_run++;
        if (fails == fails_before) begin
            $display("%s: ok", test);
        end else begin
            $display("%s: %0d checks failed", test, fails - fails_before);
        end
    endtask

    task automatic test_reset();
        int f0;
        f0 = fails;
        read_and_check("reset", `CSD_FIR_REG_STATUS, 0);
        read_and_check("reset", `CSD_FIR_REG_RESULT, 0);
        report_test("reset", f0);
    endtask

    task automatic test_impulse();
        int   f0;
        int   impulse [5];
        logic e;
        f0 = fails;
        impulse = '{-146, -1961, 2242, 12491, 0};
        for (int i = 0; i < 5; i++) begin
            apb_write(`CSD_FIR_REG_SAMPLE, (i == 0) ? 32'd1 : 32'd0, e);
            check_value("impulse", 32'd0, {31'd0, e});
            void'(model_step((i == 0) ? 1 : 0));
            read_and_check("impulse", `CSD_FIR_REG_RESULT, impulse[i]);
        end
        report_test("impulse", f0);
    endtask

    task automatic test_random();
        int f0;
        int x;
        f0 = fails;
        for (int i = 0; i < 200; i++) begin
            if (i == 0 || i == 101) begin
                x = -32768;
            end else if (i == 1 || i == 100) begin
                x = 32767;
            end else begin
                x = int'($signed(16'($urandom)));
            end
            feed_and_check("random", x);
        end
        report_test("random", f0);
    endtask

    task automatic test_status();
        int f0;
        f0 = fails;
        clear_filter("status");
        write_only("status", 100);
        read_and_check("status", `CSD_FIR_REG_STATUS, 1);
        read_and_check("status", `CSD_FIR_REG_RESULT, C0 * 100);
        read_and_check("status", `CSD_FIR_REG_STATUS, 0);
        write_only("status", -7);
        write_only("status", 25);
        read_and_check("status", `CSD_FIR_REG_STATUS, 3); // Valid and overrun.
        read_and_check("status", `CSD_FIR_REG_RESULT, C0 * 25 + C1 * -7 + C2 * 100);
        read_and_check("status", `CSD_FIR_REG_STATUS, 2);
        report_test("status", f0);
    endtask

    task automatic test_clear();
        int f0;
        f0 = fails;
        write_only("clear", 1111);
        write_only("clear", -2222);
        write_only("clear", 3333);
        clear_filter("clear");
        read_and_check("clear", `CSD_FIR_REG_STATUS, 0);
        read_and_check("clear", `CSD_FIR_REG_RESULT, 0);
        write_only("clear", -1234);
        read_and_check("clear", `CSD_FIR_REG_RESULT, C0 * -1234);
        report_test("clear", f0);
    endtask

    task automatic test_errors();
        int          f0;
        logic [31:0] d;
        logic        e;
        f0 = fails;
        feed_and_check("errors", 4321);
        apb_write(8'h10, 32'h0000_5555, e);
        check_value("errors", 32'd1, {31'd0, e});
        apb_read(8'h10, d, e);
        check_value("errors", 32'd1, {31'd0, e});
        apb_write(`CSD_FIR_REG_RESULT, 32'h0000_1234, e);
        check_value("errors", 32'd1, {31'd0, e});
        apb_read(`CSD_FIR_REG_SAMPLE, d, e);
        check_value("errors", 32'd1, {31'd0, e});
        read_and_check("errors", `CSD_FIR_REG_STATUS, 0);
        feed_and_check("errors", -999);
        report_test("errors", f0);
    endtask

    initial begin
        pclk      = 1'b0;
        rst_n     = 1'b0;
        apb_req   = '0;
        fails     = 0;
        tests_run = 0;
        model_clear();
        void'($urandom(32'hd4d7));
        repeat (8) @(posedge pclk);
        #1;
        rst_n = 1'b1;

        test_reset();
        test_impulse();
        test_random();
        test_status();
        test_clear();
        test_errors();

        $display("Tests run %0d, checks failed %0d", tests_run, fails);
        if (fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* csd_fir_top.f */
+incdir+.
logic/csd_fir_pkg.sv
logic/csd_multiplier.sv
logic/fir_datapath.sv
logic/fir_apb_regs.sv
logic/csd_fir_top.sv
bench/csd_fir_properties.sv
bench/csd_fir_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the log.
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module csd_fir_tb \
    -f csd_fir_top.f -o csd_fir_sim \
    && ./obj_dir/csd_fir_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed."; exit 1; }

cat sim.log
grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }
